// File: rtl/cpu_pkg.sv
package cpu_pkg;

	////////////////////
	// Widths and constants

	localparam int data_width = 16;
	localparam int addr_width = 14;
	localparam int prescale_width = 16; // Up to 65535 clocks per ms

	typedef logic [data_width-1:0] data_t;
	typedef logic [addr_width-1:0] addr_t;
	typedef logic [3:0] reg_addr_t;

	localparam addr_t pc_top = {addr_width{1'b1}}; // Reset vector, pc counts down
	localparam reg_addr_t box_x_reg = 4'd14; // Touch box bounds, high byte max, low byte min
	localparam reg_addr_t box_y_reg = 4'd15;

	////////////////////
	// Instruction set

	typedef enum logic [3:0] {
		op_add     = 4'h0,
		op_sub     = 4'h1,
		op_and     = 4'h2,
		op_or      = 4'h3,
		op_addi    = 4'h4, // rd = rd + imm8
		op_load    = 4'h5, // rd = mem[rb]
		op_store   = 4'h6, // mem[rb] = rd
		op_jmp     = 4'h7, // pc = pc_top - rd
		op_bz      = 4'h8,
		op_wait    = 4'h9,
		op_tchbrch = 4'ha
	} op_t;

	// imm8 is {ra, rb}, offset12 is {rd, ra, rb}
	typedef struct packed {
		op_t opcode;
		reg_addr_t rd;
		reg_addr_t ra;
		reg_addr_t rb;
	} instr_t;

	typedef struct packed {
		logic zero;
		logic negative;
	} flags_t;

	// Host load words and the outgoing store stream
	typedef struct packed {
		addr_t addr;
		data_t data;
	} mem_write_t;

	typedef struct packed {
		logic [11:0] x;
		logic [11:0] y;
	} touch_pos_t;

	typedef enum logic [3:0] {
		st_fetch,
		st_decode,
		st_alu,
		st_jmp,
		st_load1,
		st_load2,
		st_store,
		st_wait,
		st_bz,
		st_tchbrch
	} ctrl_state_t;

endpackage

// File: rtl/alu.sv
`timescale 1ns/1ps

module alu import cpu_pkg::*; (
	input op_t op,
	input data_t a,
	input data_t b, // Zero-extended imm8 for add-immediate
	output data_t result,
	output flags_t flags
);

	always_comb
	begin
		case (op)
			op_add, op_addi:
			begin
				result = a + b;
			end
			op_sub:
			begin
				result = a - b;
			end
			op_and:
			begin
				result = a & b;
			end
			op_or:
			begin
				result = a | b;
			end
			default:
			begin
				result = a + b;
			end
		endcase
	end

	// Only zero and negative are kept
	assign flags.zero = (result == '0);
	assign flags.negative = result[data_width-1];

endmodule

// File: rtl/register_file.sv
`timescale 1ns/1ps

module register_file import cpu_pkg::*; (
	input logic clk,
	input logic wait_reset,
	input logic we,
	input reg_addr_t waddr,
	input data_t wdata,
	input reg_addr_t raddr_a,
	input reg_addr_t raddr_b,
	output data_t rdata_a,
	output data_t rdata_b
);

	data_t regs [16];

	// Reads are combinational
	assign rdata_a = regs[raddr_a];
	assign rdata_b = regs[raddr_b];

	always_ff @(posedge clk)
	begin
		if (wait_reset)
		begin
			regs <= '{default: '0};
		end
		else if (we)
		begin
			regs[waddr] <= wdata;
		end
	end

endmodule

// File: rtl/unified_memory.sv
`timescale 1ns/1ps

module unified_memory import cpu_pkg::*; (
	input logic clk,
	input addr_t cpu_addr,
	input logic cpu_we,
	input data_t cpu_wdata,
	input mem_write_t host,
	input logic host_we,
	output data_t rdata
);

	data_t mem [2**addr_width]; // Program and data share one array

	////////////////////
	// Write port

	always_ff @(posedge clk)
	begin
		if (host_we)
		begin
			mem[host.addr] <= host.data; // Host wins, cpu idle anyway
		end
		else if (cpu_we)
		begin
			mem[cpu_addr] <= cpu_wdata;
		end
	end

	////////////////////
	// Read port, one cycle latency

	always_ff @(posedge clk)
	begin
		rdata <= mem[cpu_addr];
	end

endmodule

// File: rtl/cpu_control.sv
`timescale 1ns/1ps

module cpu_control import cpu_pkg::*; #(
	parameter int cycles_per_ms = 25000
) (
	input logic clk,
	input logic wait_reset,
	input logic run,
	input data_t mem_rdata,
	input data_t alu_result,
	input flags_t alu_flags,
	input data_t reg_a,
	input data_t reg_b,
	input touch_pos_t touch,
	output addr_t mem_addr,
	output logic mem_we,
	output data_t mem_wdata,
	output op_t alu_op,
	output logic alu_b_sel_imm,
	output data_t alu_imm,
	output logic reg_we,
	output reg_addr_t reg_waddr,
	output reg_addr_t reg_raddr_a,
	output reg_addr_t reg_raddr_b,
	output data_t reg_wdata,
	output mem_write_t store,
	output logic store_valid,
	input logic store_ready
);

	ctrl_state_t state, next_state;
	instr_t ir;
	addr_t pc;
	flags_t saved_flags;
	op_t fetched_op;
	logic [11:0] offset12;
	addr_t branch_off;
	logic [prescale_width-1:0] prescale;
	logic [11:0] ms_count;
	logic pc_dec, pc_branch, pc_jump;
	logic flags_we;
	logic wait_count, wait_clear;
	logic touch_hit;

	assign fetched_op = op_t'(mem_rdata[15:12]); // Instruction word arrives in decode
	assign offset12 = {ir.rd, ir.ra, ir.rb};
	assign branch_off = {{(addr_width - 12){offset12[11]}}, offset12};

	// Strictly inside the box, edges do not count
	assign touch_hit = (touch.x[11:4] > reg_a[7:0]) && (touch.x[11:4] < reg_a[15:8])
		&& (touch.y[11:4] > reg_b[7:0]) && (touch.y[11:4] < reg_b[15:8]);

	// Store data goes through the ALU as rd + 0
	assign mem_wdata = alu_result;
	assign store.addr = reg_b[addr_width-1:0];
	assign store.data = alu_result;
	assign store_valid = (state == st_store);
	assign mem_we = store_valid && store_ready;

	assign reg_waddr = ir.rd;
	assign reg_wdata = (state == st_load2) ? mem_rdata : alu_result;

	////////////////////
	// Next state and datapath steering

	always_comb
	begin
		next_state = st_fetch;
		mem_addr = pc;
		alu_op = op_addi; // Pass-through of rd for jump and store
		alu_b_sel_imm = 1'b1;
		alu_imm = '0;
		reg_we = 1'b0;
		reg_raddr_a = ir.rd;
		reg_raddr_b = ir.rb;
		pc_dec = 1'b0;
		pc_branch = 1'b0;
		pc_jump = 1'b0;
		flags_we = 1'b0;
		wait_count = 1'b0;
		wait_clear = 1'b0;

		case (state)
			st_fetch:
				next_state = st_decode;
			st_decode:
			begin
				case (fetched_op)
					op_load: next_state = st_load1;
					op_store: next_state = st_store;
					op_jmp: next_state = st_jmp;
					op_bz: next_state = st_bz;
					op_wait: next_state = st_wait;
					op_tchbrch: next_state = st_tchbrch;
					default: next_state = st_alu; // Register and immediate ops
				endcase
			end
			st_alu:
			begin
				alu_op = ir.opcode;
				alu_b_sel_imm = (ir.opcode == op_addi);
				alu_imm = {8'h00, ir.ra, ir.rb};
				if (ir.opcode != op_addi)
				begin
					reg_raddr_a = ir.ra;
				end
				reg_we = 1'b1;
				flags_we = 1'b1;
				pc_dec = 1'b1;
			end
			st_jmp:
				pc_jump = 1'b1;
			st_load1:
			begin
				mem_addr = reg_b[addr_width-1:0]; // Address from rb
				next_state = st_load2;
			end
			st_load2:
			begin
				reg_we = 1'b1;
				pc_dec = 1'b1;
			end
			st_store:
			begin
				mem_addr = reg_b[addr_width-1:0];
				if (store_ready)
				begin
					pc_dec = 1'b1;
				end
				else
				begin
					next_state = st_store; // Hold until the stream takes it
				end
			end
			st_wait:
			begin
				if (ms_count == offset12)
				begin
					wait_clear = 1'b1;
					pc_dec = 1'b1;
				end
				else
				begin
					wait_count = 1'b1;
					next_state = st_wait;
				end
			end
			st_bz:
			begin
				pc_branch = saved_flags.zero;
				pc_dec = !saved_flags.zero;
			end
			st_tchbrch:
			begin
				reg_raddr_a = box_x_reg;
				reg_raddr_b = box_y_reg;
				pc_branch = touch_hit;
				pc_dec = !touch_hit;
			end
			default:
				next_state = st_fetch;
		endcase
	end

	////////////////////
	// State, pc and flags

	always_ff @(posedge clk)
	begin
		if (wait_reset)
		begin
			state <= st_fetch;
			pc <= pc_top;
			saved_flags <= '0;
		end
		else if (!run)
		begin
			state <= st_fetch; // Parked while the host loads
			pc <= pc_top;
		end
		else
		begin
			state <= next_state;
			if (flags_we)
			begin
				saved_flags <= alu_flags;
			end
			if (pc_jump)
			begin
				pc <= pc_top - alu_result[addr_width-1:0];
			end
			else if (pc_branch)
			begin
				pc <= pc - branch_off;
			end
			else if (pc_dec)
			begin
				pc <= pc - 1'b1;
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (state == st_decode)
		begin
			ir <= instr_t'(mem_rdata);
		end
	end

	////////////////////
	// Millisecond timer for wait

	always_ff @(posedge clk)
	begin
		if (wait_reset || wait_clear)
		begin
			prescale <= '0;
			ms_count <= '0;
		end
		else if (wait_count)
		begin
			if (prescale == prescale_width'(cycles_per_ms - 1))
			begin
				prescale <= '0;
				ms_count <= ms_count + 1'b1;
			end
			else
			begin
				prescale <= prescale + 1'b1;
			end
		end
	end

endmodule

// File: rtl/cpu_top.sv
`timescale 1ns/1ps

module cpu_top import cpu_pkg::*; #(
	parameter int cycles_per_ms = 25000
) (
	input logic clk,
	input logic wait_reset,
	input logic run,
	input mem_write_t load,
	input logic load_valid,
	output logic load_ready,
	input touch_pos_t touch,
	output mem_write_t store,
	output logic store_valid,
	input logic store_ready
);

	addr_t mem_addr;
	logic mem_we;
	data_t mem_wdata, mem_rdata;
	op_t alu_op;
	logic alu_b_sel_imm;
	data_t alu_imm, alu_b, alu_result;
	flags_t alu_flags;
	logic reg_we;
	reg_addr_t reg_waddr, reg_raddr_a, reg_raddr_b;
	data_t reg_wdata, reg_a, reg_b;

	assign load_ready = !run; // Host loads only while stopped
	assign alu_b = alu_b_sel_imm ? alu_imm : reg_b;

	cpu_control #(
		.cycles_per_ms(cycles_per_ms)
	) control0 (
		.clk(clk), .wait_reset(wait_reset), .run(run),
		.mem_rdata(mem_rdata), .alu_result(alu_result), .alu_flags(alu_flags),
		.reg_a(reg_a), .reg_b(reg_b), .touch(touch),
		.mem_addr(mem_addr), .mem_we(mem_we), .mem_wdata(mem_wdata),
		.alu_op(alu_op), .alu_b_sel_imm(alu_b_sel_imm), .alu_imm(alu_imm),
		.reg_we(reg_we), .reg_waddr(reg_waddr),
		.reg_raddr_a(reg_raddr_a), .reg_raddr_b(reg_raddr_b), .reg_wdata(reg_wdata),
		.store(store), .store_valid(store_valid), .store_ready(store_ready)
	);

	register_file regs0 (
		.clk(clk), .wait_reset(wait_reset), .we(reg_we), .waddr(reg_waddr),
		.wdata(reg_wdata), .raddr_a(reg_raddr_a), .raddr_b(reg_raddr_b),
		.rdata_a(reg_a), .rdata_b(reg_b)
	);

	alu alu0 (
		.op(alu_op), .a(reg_a), .b(alu_b), .result(alu_result), .flags(alu_flags)
	);

	unified_memory mem0 (
		.clk(clk), .cpu_addr(mem_addr), .cpu_we(mem_we), .cpu_wdata(mem_wdata),
		.host(load), .host_we(load_valid && load_ready), .rdata(mem_rdata)
	);

endmodule

// File: verification/tb_cpu_top.sv
`timescale 1ns/1ps

module tb_cpu_top import cpu_pkg::*; ();

	localparam int n_cases = 7;
	localparam int tb_cycles_per_ms = 4;
	localparam int store_timeout = 400; // Cycles allowed per store
	localparam int ready_timeout = 20;

	logic clk;
	logic wait_reset;
	logic run;
	mem_write_t load;
	logic load_valid;
	logic load_ready;
	touch_pos_t touch;
	mem_write_t store;
	logic store_valid;
	logic store_ready;

	logic [15:0] lfsr;
	int cycle_count = 0;
	int checks = 0;
	int value_errors = 0;
	int timeouts = 0;

	// Stimulus and expected results per case
	logic [15:0] idle_word;
	logic [15:0] prog_tab [n_cases][12];
	touch_pos_t touch_tab [n_cases];
	mem_write_t exp_tab [n_cases][4];
	int n_tab [n_cases];
	int wait_tab [n_cases]; // Wait length in ms between store 0 and store 1

	cpu_top #(
		.cycles_per_ms(tb_cycles_per_ms)
	) dut0 (
		.clk(clk), .wait_reset(wait_reset), .run(run),
		.load(load), .load_valid(load_valid), .load_ready(load_ready),
		.touch(touch), .store(store), .store_valid(store_valid),
		.store_ready(store_ready)
	);

	initial
	begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	always @(posedge clk)
	begin
		cycle_count <= cycle_count + 1;
	end

	////////////////////
	// Instruction words and records

	function automatic logic [15:0] encode_reg(op_t op, reg_addr_t rd, reg_addr_t ra,
		reg_addr_t rb);
		return {op, rd, ra, rb};
	endfunction

	function automatic logic [15:0] encode_imm(op_t op, reg_addr_t rd, logic [7:0] imm8);
		return {op, rd, imm8};
	endfunction

	function automatic logic [15:0] encode_off(op_t op, logic [11:0] offset12);
		return {op, offset12};
	endfunction

	function automatic mem_write_t store_rec(addr_t addr, data_t data);
		mem_write_t rec;
		rec.addr = addr;
		rec.data = data;
		return rec;
	endfunction

	// Fibonacci LFSR with taps 16 14 13 11
	function automatic logic next_random_bit(inout logic [15:0] state);
		logic fb;
		fb = state[15] ^ state[13] ^ state[12] ^ state[10];
		state = {state[14:0], fb};
		return fb;
	endfunction

	task automatic fill_table;
		idle_word = encode_off(op_wait, 12'hfff); // Long wait parks the cpu
		// ALU ops with r3 as the store address
		prog_tab[0] = '{encode_imm(op_addi, 1, 8'h1e), encode_imm(op_addi, 2, 8'h0c),
			encode_imm(op_addi, 3, 8'h40), encode_reg(op_add, 4, 1, 2),
			encode_reg(op_store, 4, 0, 3), encode_reg(op_sub, 5, 2, 1),
			encode_reg(op_store, 5, 0, 3), encode_reg(op_and, 6, 1, 2),
			encode_reg(op_store, 6, 0, 3), encode_reg(op_or, 7, 1, 2),
			encode_reg(op_store, 7, 0, 3), idle_word};
		exp_tab[0][0] = store_rec(14'h0040, 16'd30 + 16'd12);
		exp_tab[0][1] = store_rec(14'h0040, 16'd12 - 16'd30);
		exp_tab[0][2] = store_rec(14'h0040, 16'd30 & 16'd12);
		exp_tab[0][3] = store_rec(14'h0040, 16'd30 | 16'd12);
		// Store then load back from the same address
		prog_tab[1] = '{encode_imm(op_addi, 1, 8'h5a), encode_imm(op_addi, 2, 8'h21),
			encode_reg(op_store, 1, 0, 2), encode_reg(op_load, 3, 0, 2),
			encode_imm(op_addi, 3, 8'h01), encode_imm(op_addi, 4, 8'h30),
			encode_reg(op_store, 3, 0, 4), idle_word, idle_word, idle_word,
			idle_word, idle_word};
		exp_tab[1][0] = store_rec(14'h0021, 16'h005a);
		exp_tab[1][1] = store_rec(14'h0030, 16'h005a + 16'h0001);
		// bz taken over the first store and then not taken
		prog_tab[2] = '{encode_imm(op_addi, 1, 8'h07), encode_imm(op_addi, 2, 8'h07),
			encode_imm(op_addi, 3, 8'h50), encode_reg(op_sub, 4, 1, 2),
			encode_off(op_bz, 12'd2), encode_reg(op_store, 1, 0, 3),
			encode_imm(op_addi, 5, 8'h01), encode_off(op_bz, 12'd2),
			encode_reg(op_store, 5, 0, 3), idle_word, idle_word, idle_word};
		exp_tab[2][0] = store_rec(14'h0050, 16'h0001);
		// Jump to word 6 through r1
		prog_tab[3] = '{encode_imm(op_addi, 1, 8'h06), encode_imm(op_addi, 2, 8'h60),
			encode_reg(op_jmp, 1, 0, 0), encode_reg(op_store, 1, 0, 2), idle_word,
			idle_word, encode_imm(op_addi, 3, 8'h33), encode_reg(op_store, 3, 0, 2),
			idle_word, idle_word, idle_word, idle_word};
		exp_tab[3][0] = store_rec(14'h0060, 16'h0033);
		prog_tab[4] = '{encode_imm(op_addi, 1, 8'h11), encode_imm(op_addi, 2, 8'h70),
			encode_reg(op_store, 1, 0, 2), encode_off(op_wait, 12'd5),
			encode_imm(op_addi, 1, 8'h01), encode_reg(op_store, 1, 0, 2), idle_word,
			idle_word, idle_word, idle_word, idle_word, idle_word};
		exp_tab[4][0] = store_rec(14'h0070, 16'h0011);
		exp_tab[4][1] = store_rec(14'h0070, 16'h0011 + 16'h0001);
		// Box bounds sit in data words 10 and 11 at addresses 0 - 11 and 0 - 12
		prog_tab[5] = '{encode_imm(op_addi, 1, 8'h0b), encode_reg(op_sub, 2, 0, 1),
			encode_reg(op_load, 14, 0, 2), encode_imm(op_addi, 1, 8'h01),
			encode_reg(op_sub, 2, 0, 1), encode_reg(op_load, 15, 0, 2),
			encode_off(op_tchbrch, 12'd2), encode_reg(op_store, 0, 0, 1),
			encode_reg(op_store, 1, 0, 1), idle_word, 16'h4010, 16'h3008};
		prog_tab[6] = prog_tab[5];
		touch_tab[5] = '{x: 12'h200, y: 12'h150}; // Inside the box
		touch_tab[6] = '{x: 12'h100, y: 12'h150}; // On the low x edge
		exp_tab[5][0] = store_rec(14'h000c, 16'h000c);
		exp_tab[6][0] = store_rec(14'h000c, 16'h0000);
		exp_tab[6][1] = store_rec(14'h000c, 16'h000c);
		n_tab = '{4, 2, 1, 1, 2, 1, 2};
		wait_tab = '{0, 0, 0, 0, 5, 0, 0};
		for (int c = 0; c < 5; c++)
		begin
			touch_tab[c] = '0;
		end
	endtask

	////////////////////
	// Driving and checking

	task automatic reset_dut;
		wait_reset = 1'b1;
		run = 1'b0;
		load_valid = 1'b0;
		for (int i = 0; i < 10; i++)
		begin
			@(posedge clk);
			#1;
		end
		wait_reset = 1'b0;
	endtask

	task automatic load_program(input int c);
		int t;
		for (int i = 0; i < 12; i++)
		begin
			load.addr = pc_top - addr_t'(i);
			load.data = prog_tab[c][i];
			load_valid = 1'b1;
			t = 0;
			@(negedge clk);
			while (!load_ready && t < ready_timeout)
			begin
				@(negedge clk);
				t++;
			end
			if (!load_ready)
			begin
				$display("Case %0d: load port never became ready for word %0d", c, i);
				timeouts++;
			end
			@(posedge clk); // Word written here
			#1;
		end
		load_valid = 1'b0;
	endtask

	// Sampled mid-cycle since the handshake completes on the next edge
	task automatic wait_store(output mem_write_t got, output int at, output bit found);
		found = 1'b0;
		got = '0;
		at = 0;
		for (int t = 0; t < store_timeout && !found; t++)
		begin
			@(negedge clk);
			if (store_valid && store_ready)
			begin
				got = store;
				at = cycle_count;
				found = 1'b1;
			end
			@(posedge clk);
			#1;
			store_ready = next_random_bit(lfsr);
		end
	endtask

	task automatic check_store(input mem_write_t got, input mem_write_t exp, input int c,
		input int k);
		checks++;
		if (got.addr !== exp.addr)
		begin
			$display("FAILED store.addr: got %h, expected %h (case %0d, store %0d)",
				got.addr, exp.addr, c, k);
			value_errors++;
		end
		if (got.data !== exp.data)
		begin
			$display("FAILED store.data: got %h, expected %h (case %0d, store %0d)",
				got.data, exp.data, c, k);
			value_errors++;
		end
	endtask

	task automatic check_ready(input logic got, input logic exp, input int c);
		checks++;
		if (got !== exp)
		begin
			$display("FAILED load_ready: got %h, expected %h (case %0d)", got, exp, c);
			value_errors++;
		end
	endtask

	task automatic check_cycles(input int got, input int min_cycles, input int c);
		checks++;
		if (got < min_cycles)
		begin
			$display("FAILED wait_gap: got %h cycles, expected at least %h (case %0d)",
				got, min_cycles, c);
			value_errors++;
		end
	endtask

	initial
	begin
		int at;
		int prev_at;
		bit ok;
		mem_write_t got;
		wait_reset = 1'b1;
		run = 1'b0;
		load = '0;
		load_valid = 1'b0;
		touch = '0;
		store_ready = 1'b0;
		lfsr = 16'd15;
		fill_table();
		for (int c = 0; c < n_cases; c++)
		begin
			reset_dut();
			touch = touch_tab[c];
			load_program(c);
			run = 1'b1;
			ok = 1'b1;
			prev_at = 0;
			for (int k = 0; k < n_tab[c] && ok; k++)
			begin
				wait_store(got, at, ok);
				if (!ok)
				begin
					$display("Case %0d: store %0d did not arrive within %0d cycles",
						c, k, store_timeout);
					timeouts++;
				end
				else
				begin
					check_store(got, exp_tab[c][k], c, k);
					check_ready(load_ready, 1'b0, c); // Host port closed while running
					if (k > 0 && wait_tab[c] > 0)
					begin
						check_cycles(at - prev_at, wait_tab[c] * tb_cycles_per_ms, c);
					end
					prev_at = at;
				end
			end
			run = 1'b0;
		end
		$display("Checks: %0d, value errors: %0d, timeouts: %0d", checks, value_errors,
			timeouts);
		if (value_errors == 0 && timeouts == 0)
		begin
			$display("Done: no errors");
		end
		else
		begin
			$display("Done: errors found");
		end
		$finish;
	end

endmodule

// File: cpu_top.f
rtl/cpu_pkg.sv
rtl/alu.sv
rtl/register_file.sv
rtl/unified_memory.sv
rtl/cpu_control.sv
rtl/cpu_top.sv
verification/tb_cpu_top.sv

// File: run_sim.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -f cpu_top.f --top-module tb_cpu_top -o tb_cpu_top
output=$(./obj_dir/tb_cpu_top)
echo "$output"

if echo "$output" | grep -qx "Done: no errors"; then
	exit 0
fi
exit 1
